//--- source/rs_cfg_pkg.sv
// Reservation station configuration

package rs_cfg_pkg;

  // ====================
  // Datapath widths
  // ====================

  // Operand, CDB value and immediate width
  localparam int unsigned XLEN = 32;

  // ROB tag width, ages wrap modulo 2**ROB_TAG_W
  localparam int unsigned ROB_TAG_W = 5;

  // Opaque operation code, passed through untouched
  localparam int unsigned OP_W = 8;

  // ====================
  // Station geometry
  // ====================

  // Number of entries, all held in flops
  localparam int unsigned RS_DEPTH = 8;

  // Slot index width
  localparam int unsigned RS_IDX_W = $clog2(RS_DEPTH);

  // Occupancy count width, must reach RS_DEPTH itself
  localparam int unsigned RS_CNT_W = $clog2(RS_DEPTH + 1);

  // Zero padding above a pending tag inside an operand word
  localparam int unsigned TAG_PAD_W = XLEN - ROB_TAG_W;

endpackage

//--- source/rs_types_pkg.sv
// Reservation station types

package rs_types_pkg;

  import rs_cfg_pkg::*;

  // ====================
  // Scalar types
  // ====================

  typedef logic [ROB_TAG_W-1:0] rob_tag_t;
  typedef logic [RS_IDX_W-1:0] rs_idx_t;

  // ====================
  // Operand word
  // ====================

  // Pending view, tag in the low bits
  typedef struct packed {
    logic [TAG_PAD_W-1:0] pad;
    rob_tag_t             tag;
  } pending_op_t;

  // Value once ready, producer tag while pending
  typedef union packed {
    logic [XLEN-1:0] value;
    pending_op_t     pending;
  } operand_u;

  // Source operand with its ready bit
  typedef struct packed {
    logic     ready;
    operand_u data;
  } src_t;

  // ====================
  // Interface records
  // ====================

  // Dispatch record, also the stored entry format
  typedef struct packed {
    logic            valid;
    rob_tag_t        rob_tag;
    logic [OP_W-1:0] op;
    src_t            src1;
    src_t            src2;
    logic            use_imm;
    logic [XLEN-1:0] imm;
  } dispatch_t;

  // Common data bus broadcast
  typedef struct packed {
    logic            valid;
    rob_tag_t        tag;
    logic [XLEN-1:0] value;
  } cdb_t;

  // Packet to the functional unit
  typedef struct packed {
    logic            valid;
    rob_tag_t        rob_tag;
    logic [OP_W-1:0] op;
    logic [XLEN-1:0] src1_value;
    logic [XLEN-1:0] src2_value;
    logic            use_imm;
    logic [XLEN-1:0] imm;
  } issue_t;

  // Flush request kinds
  typedef enum logic [1:0] {
    FLUSH_NONE    = 2'd0,
    FLUSH_PARTIAL = 2'd1,
    FLUSH_ALL     = 2'd2
  } flush_kind_e;

  // Decoded flush command
  typedef struct packed {
    flush_kind_e kind;
    rob_tag_t    flush_tag;
    rob_tag_t    head_tag;
  } flush_cmd_t;

endpackage

//--- source/rs_dispatch_decode.sv
// Dispatch and flush decode

`timescale 1ns/1ps

module rs_dispatch_decode
  import rs_cfg_pkg::*;
  import rs_types_pkg::*;
(
  input  dispatch_t           i_dispatch,
  input  cdb_t                i_cdb,
  input  logic [RS_DEPTH-1:0] i_valid_vec,
  input  logic                i_flush_en,
  input  logic                i_flush_all,
  input  rob_tag_t            i_flush_tag,
  input  rob_tag_t            i_rob_head_tag,
  output logic                o_wr_en,
  output rs_idx_t             o_wr_idx,
  output dispatch_t           o_wr_entry,
  output flush_cmd_t          o_flush,
  output logic                o_hold
);

  logic    free_found;
  rs_idx_t free_idx;
  logic    flush_any;

  // Switch a pending source to the CDB value when its producer broadcasts now
  function automatic src_t bypass_src(input src_t src, input cdb_t cdb);
    src_t res;
    res = src;
    if (!src.ready && cdb.valid && (src.data.pending.tag == cdb.tag)) begin
      res.ready      = 1'b1;
      res.data.value = cdb.value;
    end
    return res;
  endfunction

  // ====================
  // Free slot search
  // ====================

  // Lowest invalid slot wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (!i_valid_vec[i] && !free_found) begin
        free_found = 1'b1;
        free_idx   = RS_IDX_W'(i);
      end
    end
  end

  assign flush_any = i_flush_en | i_flush_all;

  // No free slot means full, flush blocks new work
  assign o_wr_en  = i_dispatch.valid & free_found & ~flush_any;
  assign o_wr_idx = free_idx;

  // Entry record with same-cycle CDB capture on both sources
  always_comb begin
    o_wr_entry      = i_dispatch;
    o_wr_entry.src1 = bypass_src(i_dispatch.src1, i_cdb);
    o_wr_entry.src2 = bypass_src(i_dispatch.src2, i_cdb);
  end

  // ====================
  // Flush command
  // ====================

  // Full flush overrides a partial one
  always_comb begin
    if (i_flush_all) begin
      o_flush.kind = FLUSH_ALL;
    end else if (i_flush_en) begin
      o_flush.kind = FLUSH_PARTIAL;
    end else begin
      o_flush.kind = FLUSH_NONE;
    end
    o_flush.flush_tag = i_flush_tag;
    o_flush.head_tag  = i_rob_head_tag;
  end

  // Issue stalls for the whole flush cycle
  assign o_hold = flush_any;

endmodule

//--- source/rs_entry_array.sv
// Reservation station entry array

`timescale 1ns/1ps

module rs_entry_array
  import rs_cfg_pkg::*;
  import rs_types_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_wr_en,
  input  rs_idx_t             i_wr_idx,
  input  dispatch_t           i_wr_entry,
  input  cdb_t                i_cdb,
  input  flush_cmd_t          i_flush,
  input  logic                i_clr_en,
  input  rs_idx_t             i_clr_idx,
  output logic [RS_DEPTH-1:0] o_valid_vec,
  output logic [RS_DEPTH-1:0] o_src1_rdy,
  output logic [RS_DEPTH-1:0] o_src2_rdy,
  output logic [RS_DEPTH-1:0] o_use_imm,
  output dispatch_t           o_entries [RS_DEPTH],
  output logic [RS_CNT_W-1:0] o_count,
  output logic                o_full,
  output logic                o_empty
);

  // Control state
  logic [RS_DEPTH-1:0] valid_q;
  logic [RS_DEPTH-1:0] src1_rdy_q;
  logic [RS_DEPTH-1:0] src2_rdy_q;

  // Payload, valid and ready fields shadowed by the control flops
  dispatch_t entry_q [RS_DEPTH];

  logic [RS_DEPTH-1:0] wake1;
  logic [RS_DEPTH-1:0] wake2;
  logic [RS_DEPTH-1:0] flush_mask;
  logic                wr_fire;
  logic [RS_CNT_W-1:0] count;

  // Age is distance from the ROB head, wrapping with the tag width
  function automatic logic is_younger(input rob_tag_t tag, input rob_tag_t flush_tag,
                                      input rob_tag_t head);
    rob_tag_t tag_age;
    rob_tag_t flush_age;
    tag_age   = tag - head;
    flush_age = flush_tag - head;
    return tag_age > flush_age;
  endfunction

  // ====================
  // CDB snoop and flush match
  // ====================

  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      // Only pending sources of live entries listen
      wake1[i] = valid_q[i] && !src1_rdy_q[i] && i_cdb.valid &&
                 (entry_q[i].src1.data.pending.tag == i_cdb.tag);
      wake2[i] = valid_q[i] && !src2_rdy_q[i] && i_cdb.valid &&
                 (entry_q[i].src2.data.pending.tag == i_cdb.tag);
      // Entries younger than the flush point
      flush_mask[i] = valid_q[i] &&
                      is_younger(entry_q[i].rob_tag, i_flush.flush_tag, i_flush.head_tag);
    end
  end

  // Any flush blocks a write
  assign wr_fire = i_wr_en && (i_flush.kind == FLUSH_NONE);

  // ====================
  // Control flops
  // ====================

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q    <= '0;
      src1_rdy_q <= '0;
      src2_rdy_q <= '0;
    end else begin
      // Wakeup also runs during flush for the survivors
      src1_rdy_q <= src1_rdy_q | wake1;
      src2_rdy_q <= src2_rdy_q | wake2;
      case (i_flush.kind)
        FLUSH_ALL: begin
          valid_q <= '0;
        end
        FLUSH_PARTIAL: begin
          valid_q <= valid_q & ~flush_mask;
        end
        default: begin
          // Issued slot frees at the issue edge
          if (i_clr_en) begin
            valid_q[i_clr_idx] <= 1'b0;
          end
          // New entry, bypass already applied by decode
          if (wr_fire) begin
            valid_q[i_wr_idx]    <= 1'b1;
            src1_rdy_q[i_wr_idx] <= i_wr_entry.src1.ready;
            src2_rdy_q[i_wr_idx] <= i_wr_entry.src2.ready;
          end
        end
      endcase
    end
  end

  // ====================
  // Payload flops
  // ====================

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      // CDB value overwrites the tag in the operand word
      if (wake1[i]) begin
        entry_q[i].src1.data.value <= i_cdb.value;
      end
      if (wake2[i]) begin
        entry_q[i].src2.data.value <= i_cdb.value;
      end
    end
    if (wr_fire) begin
      entry_q[i_wr_idx] <= i_wr_entry;
    end
  end

  // Records seen by issue select carry the live control bits
  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      o_entries[i]            = entry_q[i];
      o_entries[i].valid      = valid_q[i];
      o_entries[i].src1.ready = src1_rdy_q[i];
      o_entries[i].src2.ready = src2_rdy_q[i];
      o_use_imm[i]            = entry_q[i].use_imm;
    end
  end

  assign o_valid_vec = valid_q;
  assign o_src1_rdy  = src1_rdy_q;
  assign o_src2_rdy  = src2_rdy_q;

  // Occupancy as popcount of the valid vector
  always_comb begin
    count = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      count = count + RS_CNT_W'(valid_q[i]);
    end
  end

  assign o_count = count;
  assign o_full  = (count == RS_CNT_W'(RS_DEPTH));
  assign o_empty = (count == '0);

endmodule

//--- source/rs_issue_select.sv
// Issue selection

`timescale 1ns/1ps

module rs_issue_select
  import rs_cfg_pkg::*;
  import rs_types_pkg::*;
(
  input  logic [RS_DEPTH-1:0] i_valid_vec,
  input  logic [RS_DEPTH-1:0] i_src1_rdy,
  input  logic [RS_DEPTH-1:0] i_src2_rdy,
  input  logic [RS_DEPTH-1:0] i_use_imm,
  input  dispatch_t           i_entries [RS_DEPTH],
  input  logic                i_fu_ready,
  input  logic                i_hold,
  output issue_t              o_issue,
  output logic                o_clr_en,
  output rs_idx_t             o_clr_idx
);

  logic [RS_DEPTH-1:0] entry_rdy;
  logic                any_rdy;
  rs_idx_t             sel_idx;
  logic                fire;

  // Immediate stands in for source 2
  assign entry_rdy = i_valid_vec & i_src1_rdy & (i_src2_rdy | i_use_imm);

  // Lowest ready index, which is also the oldest when slots fill in order
  always_comb begin
    any_rdy = 1'b0;
    sel_idx = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (entry_rdy[i] && !any_rdy) begin
        any_rdy = 1'b1;
        sel_idx = RS_IDX_W'(i);
      end
    end
  end

  // FU back-pressure and flush both stall issue
  assign fire = any_rdy & i_fu_ready & ~i_hold;

  assign o_clr_en  = fire;
  assign o_clr_idx = sel_idx;

  // Packet is all zero when nothing issues
  always_comb begin
    o_issue = '0;
    if (fire) begin
      o_issue.valid      = 1'b1;
      o_issue.rob_tag    = i_entries[sel_idx].rob_tag;
      o_issue.op         = i_entries[sel_idx].op;
      o_issue.src1_value = i_entries[sel_idx].src1.data.value;
      o_issue.src2_value = i_entries[sel_idx].src2.data.value;
      o_issue.use_imm    = i_use_imm[sel_idx];
      o_issue.imm        = i_entries[sel_idx].imm;
    end
  end

endmodule

//--- source/reservation_station.sv
// Reservation station top level

`timescale 1ns/1ps

module reservation_station
  import rs_cfg_pkg::*;
  import rs_types_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  dispatch_t           i_dispatch,
  output logic                o_full,
  input  cdb_t                i_cdb,
  output issue_t              o_issue,
  input  logic                i_fu_ready,
  input  logic                i_flush_en,
  input  logic                i_flush_all,
  input  rob_tag_t            i_flush_tag,
  input  rob_tag_t            i_rob_head_tag,
  output logic                o_empty,
  output logic [RS_CNT_W-1:0] o_count
);

  // Decode to array
  logic       wr_en;
  rs_idx_t    wr_idx;
  dispatch_t  wr_entry;
  flush_cmd_t flush_cmd;

  // Decode to issue select
  logic hold;

  // Array to decode and issue select
  logic [RS_DEPTH-1:0] valid_vec;
  logic [RS_DEPTH-1:0] src1_rdy;
  logic [RS_DEPTH-1:0] src2_rdy;
  logic [RS_DEPTH-1:0] use_imm;
  dispatch_t           entries [RS_DEPTH];

  // Issue select back to array
  logic    clr_en;
  rs_idx_t clr_idx;

  // ====================
  // Stages
  // ====================

  rs_dispatch_decode u_decode (
    .i_dispatch     (i_dispatch),
    .i_cdb          (i_cdb),
    .i_valid_vec    (valid_vec),
    .i_flush_en     (i_flush_en),
    .i_flush_all    (i_flush_all),
    .i_flush_tag    (i_flush_tag),
    .i_rob_head_tag (i_rob_head_tag),
    .o_wr_en        (wr_en),
    .o_wr_idx       (wr_idx),
    .o_wr_entry     (wr_entry),
    .o_flush        (flush_cmd),
    .o_hold         (hold)
  );

  rs_entry_array u_array (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wr_en     (wr_en),
    .i_wr_idx    (wr_idx),
    .i_wr_entry  (wr_entry),
    .i_cdb       (i_cdb),
    .i_flush     (flush_cmd),
    .i_clr_en    (clr_en),
    .i_clr_idx   (clr_idx),
    .o_valid_vec (valid_vec),
    .o_src1_rdy  (src1_rdy),
    .o_src2_rdy  (src2_rdy),
    .o_use_imm   (use_imm),
    .o_entries   (entries),
    .o_count     (o_count),
    .o_full      (o_full),
    .o_empty     (o_empty)
  );

  rs_issue_select u_issue (
    .i_valid_vec (valid_vec),
    .i_src1_rdy  (src1_rdy),
    .i_src2_rdy  (src2_rdy),
    .i_use_imm   (use_imm),
    .i_entries   (entries),
    .i_fu_ready  (i_fu_ready),
    .i_hold      (hold),
    .o_issue     (o_issue),
    .o_clr_en    (clr_en),
    .o_clr_idx   (clr_idx)
  );

endmodule

//--- dv/rs_asserts.sv
// Reservation station protocol assertions

`timescale 1ns/1ps

module rs_asserts
  import rs_cfg_pkg::*;
  import rs_types_pkg::*;
(
  input logic                i_clk,
  input logic                i_rst_n,
  input logic                o_full,
  input logic                o_empty,
  input issue_t              o_issue,
  input logic                i_flush_en,
  input logic                i_flush_all,
  input logic [RS_CNT_W-1:0] o_count
);

  // Failure tally, read by the testbench at the end
  int assert_fails = 0;

  // Status flags are exclusive
  full_xor_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_full && o_empty))
    else begin
      $error("full and empty high together");
      assert_fails++;
    end

  // Flush stalls issue for the whole cycle
  no_issue_in_flush: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_issue.valid |-> !(i_flush_en || i_flush_all))
    else begin
      $error("issue during flush");
      assert_fails++;
    end

  count_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_count <= RS_CNT_W'(RS_DEPTH))
    else begin
      $error("count above depth");
      assert_fails++;
    end

endmodule

bind reservation_station rs_asserts u_asserts (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .o_full      (o_full),
  .o_empty     (o_empty),
  .o_issue     (o_issue),
  .i_flush_en  (i_flush_en),
  .i_flush_all (i_flush_all),
  .o_count     (o_count)
);

//--- dv/rs_tb.sv
// Reservation station testbench

`timescale 1ns/1ps

module rs_tb
  import rs_cfg_pkg::*;
  import rs_types_pkg::*;
();

  // ====================
  // Bench constants
  // ====================

  localparam int          CLK_PERIOD    = 100;
  localparam int          SETTLE        = 10;
  localparam int          RESET_CYCLES  = 10;
  localparam int          ISSUE_TIMEOUT = 20;
  localparam logic [15:0] LFSR_SEED     = 16'd41505;

  logic                i_clk;
  logic                i_rst_n;
  dispatch_t           dispatch;
  cdb_t                cdb;
  logic                fu_ready;
  logic                flush_en;
  logic                flush_all;
  rob_tag_t            flush_tag;
  rob_tag_t            head_tag;
  logic                full;
  logic                empty;
  issue_t              issue;
  logic [RS_CNT_W-1:0] count;

  logic [15:0] lfsr_q;
  int          err_count;
  int          check_count;

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  reservation_station DUT (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_dispatch     (dispatch),
    .o_full         (full),
    .i_cdb          (cdb),
    .o_issue        (issue),
    .i_fu_ready     (fu_ready),
    .i_flush_en     (flush_en),
    .i_flush_all    (flush_all),
    .i_flush_tag    (flush_tag),
    .i_rob_head_tag (head_tag),
    .o_empty        (empty),
    .o_count        (count)
  );

  // ====================
  // Stimulus helpers
  // ====================

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] res;
    logic        fb;
    res = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      res    = {res[30:0], fb};
    end
    return res;
  endfunction

  function automatic src_t ready_src(input logic [XLEN-1:0] value);
    src_t s;
    s.ready      = 1'b1;
    s.data.value = value;
    return s;
  endfunction

  // Pending word holds the producer tag with zeros above
  function automatic src_t pending_src(input rob_tag_t tag);
    src_t s;
    s.ready            = 1'b0;
    s.data.pending.pad = '0;
    s.data.pending.tag = tag;
    return s;
  endfunction

  function automatic dispatch_t make_disp(input rob_tag_t tag, input src_t s1, input src_t s2,
                                          input logic use_imm);
    dispatch_t d;
    d.valid   = 1'b1;
    d.rob_tag = tag;
    d.op      = OP_W'(rand_bits(OP_W));
    d.src1    = s1;
    d.src2    = s2;
    d.use_imm = use_imm;
    d.imm     = rand_bits(XLEN);
    return d;
  endfunction

  // Packet the FU should see for an entry with these operand words
  function automatic issue_t expect_pkt(input dispatch_t d, input logic [XLEN-1:0] v1,
                                        input logic [XLEN-1:0] v2);
    issue_t p;
    p.valid      = 1'b1;
    p.rob_tag    = d.rob_tag;
    p.op         = d.op;
    p.src1_value = v1;
    p.src2_value = v2;
    p.use_imm    = d.use_imm;
    p.imm        = d.imm;
    return p;
  endfunction

  // ====================
  // Checks and waits
  // ====================

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    assert (act === exp) else begin
      $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
      err_count++;
    end
  endtask

  // Full and empty follow directly from the count
  task automatic check_status(input string name, input int exp_count);
    check_val({name, " count"}, 32'(exp_count), 32'(count));
    check_val({name, " full"}, 32'(exp_count == RS_DEPTH), 32'(full));
    check_val({name, " empty"}, 32'(exp_count == 0), 32'(empty));
  endtask

  // Starts on a falling edge and ends on the falling edge after the issue
  task automatic expect_issue(input string name, input issue_t exp);
    int cyc;
    cyc = 0;
    #SETTLE;
    while (!issue.valid && cyc < ISSUE_TIMEOUT) begin
      @(negedge i_clk);
      #SETTLE;
      cyc++;
    end
    check_count++;
    assert (issue.valid) else begin
      $display("%s: no issue within %0d cycles", name, ISSUE_TIMEOUT);
      err_count++;
    end
    if (issue.valid) begin
      check_count++;
      assert (issue === exp) else begin
        $display("ERROR %s: expected %h, actual %h", name, exp, issue);
        err_count++;
      end
    end
    @(negedge i_clk);
  endtask

  task automatic expect_no_issue(input string name, input int cycles);
    repeat (cycles) begin
      #SETTLE;
      check_val({name, " issue valid"}, 32'd0, 32'(issue.valid));
      @(negedge i_clk);
    end
  endtask

  // One dispatch cycle accepted at the rising edge in between
  task automatic dispatch_one(input dispatch_t d);
    dispatch = d;
    @(negedge i_clk);
    dispatch = '0;
  endtask

  task automatic broadcast(input rob_tag_t tag, input logic [XLEN-1:0] value);
    cdb.valid = 1'b1;
    cdb.tag   = tag;
    cdb.value = value;
    @(negedge i_clk);
    cdb = '0;
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic test_ready_issue();
    dispatch_t d;
    fu_ready = 1'b1;
    d = make_disp(rob_tag_t'(rand_bits(ROB_TAG_W)), ready_src(rand_bits(XLEN)),
                  ready_src(rand_bits(XLEN)), 1'b0);
    dispatch_one(d);
    expect_issue("ready_issue", expect_pkt(d, d.src1.data.value, d.src2.data.value));
    check_status("ready_issue", 0);
  endtask

  task automatic test_wakeup_bypass();
    dispatch_t       a;
    dispatch_t       b;
    rob_tag_t        t1;
    rob_tag_t        t2;
    logic [XLEN-1:0] v1;
    logic [XLEN-1:0] v2;
    t1 = rob_tag_t'(rand_bits(ROB_TAG_W));
    t2 = t1 + rob_tag_t'(1);
    v1 = rand_bits(XLEN);
    v2 = rand_bits(XLEN);
    fu_ready = 1'b1;
    a = make_disp(rob_tag_t'(rand_bits(ROB_TAG_W)), pending_src(t1),
                  ready_src(rand_bits(XLEN)), 1'b0);
    dispatch_one(a);
    // Must sit until its producer broadcasts
    expect_no_issue("wakeup wait", 3);
    broadcast(t1, v1);
    expect_issue("wakeup", expect_pkt(a, v1, a.src2.data.value));
    // Producer result on the CDB in the accept cycle
    b = make_disp(rob_tag_t'(rand_bits(ROB_TAG_W)), pending_src(t2),
                  ready_src(rand_bits(XLEN)), 1'b0);
    cdb.valid = 1'b1;
    cdb.tag   = t2;
    cdb.value = v2;
    dispatch_one(b);
    cdb = '0;
    expect_issue("bypass", expect_pkt(b, v2, b.src2.data.value));
    check_status("wakeup_bypass", 0);
  endtask

  task automatic test_imm_bypass();
    dispatch_t       d;
    rob_tag_t        t1;
    rob_tag_t        t2;
    logic [XLEN-1:0] v1;
    t1 = rob_tag_t'(rand_bits(ROB_TAG_W));
    t2 = t1 ^ rob_tag_t'(5'h10);
    v1 = rand_bits(XLEN);
    fu_ready = 1'b1;
    d = make_disp(rob_tag_t'(rand_bits(ROB_TAG_W)), pending_src(t1), pending_src(t2), 1'b1);
    dispatch_one(d);
    expect_no_issue("imm wait", 2);
    broadcast(t1, v1);
    // Source 2 never wakes so its word still holds the tag
    expect_issue("imm_bypass", expect_pkt(d, v1, XLEN'(t2)));
    check_status("imm_bypass", 0);
  endtask

  task automatic test_fill_drain();
    dispatch_t ent [RS_DEPTH];
    dispatch_t extra;
    int        i;
    fu_ready = 1'b0;
    for (i = 0; i < RS_DEPTH; i++) begin
      ent[i] = make_disp(rob_tag_t'(i), ready_src(rand_bits(XLEN)),
                         ready_src(rand_bits(XLEN)), 1'b0);
      dispatch_one(ent[i]);
      check_status("fill", i + 1);
    end
    // Dropped while full
    extra = make_disp(rob_tag_t'(RS_DEPTH), ready_src(rand_bits(XLEN)),
                      ready_src(rand_bits(XLEN)), 1'b0);
    dispatch_one(extra);
    check_status("fill extra", RS_DEPTH);
    expect_no_issue("fill stall", 2);
    fu_ready = 1'b1;
    for (i = 0; i < RS_DEPTH; i++) begin
      expect_issue("drain", expect_pkt(ent[i], ent[i].src1.data.value, ent[i].src2.data.value));
    end
    check_status("drain", 0);
  endtask

  task automatic test_flush();
    dispatch_t ent [6];
    int        k;
    fu_ready = 1'b0;
    head_tag = rob_tag_t'(rand_bits(ROB_TAG_W));
    // Ages 1 to 6 relative to the head with wrap
    for (k = 0; k < 6; k++) begin
      ent[k] = make_disp(rob_tag_t'(head_tag + k + 1), ready_src(rand_bits(XLEN)),
                         ready_src(rand_bits(XLEN)), 1'b0);
      dispatch_one(ent[k]);
    end
    check_status("flush fill", 6);
    flush_tag = rob_tag_t'(head_tag + 3);
    flush_en  = 1'b1;
    @(negedge i_clk);
    flush_en = 1'b0;
    check_status("partial flush", 3);
    fu_ready = 1'b1;
    for (k = 0; k < 3; k++) begin
      expect_issue("flush survivor",
                   expect_pkt(ent[k], ent[k].src1.data.value, ent[k].src2.data.value));
    end
    expect_no_issue("flush removed", 3);
    check_status("flush drain", 0);
    // Refill and drop everything
    fu_ready = 1'b0;
    for (k = 0; k < 4; k++) begin
      dispatch_one(make_disp(rob_tag_t'(head_tag + k + 1), ready_src(rand_bits(XLEN)),
                             ready_src(rand_bits(XLEN)), 1'b0));
    end
    check_status("refill", 4);
    flush_all = 1'b1;
    fu_ready  = 1'b1;
    #SETTLE;
    check_val("flush_all issue valid", 32'd0, 32'(issue.valid));
    @(negedge i_clk);
    flush_all = 1'b0;
    check_status("flush_all", 0);
    expect_no_issue("flush_all", 3);
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    err_count   = 0;
    check_count = 0;
    lfsr_q      = LFSR_SEED;
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    dispatch    = '0;
    cdb         = '0;
    fu_ready    = 1'b0;
    flush_en    = 1'b0;
    flush_all   = 1'b0;
    flush_tag   = '0;
    head_tag    = '0;
    repeat (RESET_CYCLES) @(negedge i_clk);
    i_rst_n = 1'b1;
    check_val("reset issue valid", 32'd0, 32'(issue.valid));
    check_status("reset", 0);

    test_ready_issue();
    test_wakeup_bypass();
    test_imm_bypass();
    test_fill_drain();
    test_flush();

    $display("checks %0d, errors %0d, assertion failures %0d",
             check_count, err_count, DUT.u_asserts.assert_fails);
    if (err_count == 0 && DUT.u_asserts.assert_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- sources.f
source/rs_cfg_pkg.sv
source/rs_types_pkg.sv
source/rs_dispatch_decode.sv
source/rs_entry_array.sv
source/rs_issue_select.sv
source/reservation_station.sv
dv/rs_asserts.sv
dv/rs_tb.sv

//--- Bender.yml
package:
  name: reservation_station

sources:
  # Packages first, then the stages and the top level
  - source/rs_cfg_pkg.sv
  - source/rs_types_pkg.sv
  - source/rs_dispatch_decode.sv
  - source/rs_entry_array.sv
  - source/rs_issue_select.sv
  - source/reservation_station.sv

  # Verification files
  - target: simulation
    files:
      - dv/rs_asserts.sv
      - dv/rs_tb.sv
